// File: src/rs_pkg.sv
`default_nettype none

package rs_pkg;

    // Field widths used across the scheduler
    localparam int PREG_W      = 6;
    localparam int OPCODE_W    = 4;
    localparam int FUNIT_W     = 2;
    localparam int ENTRY_IDX_W = 3;

    // Largest bank that the entry index can address
    localparam int MAX_RS_ENTRIES = 1 << ENTRY_IDX_W;

    // Physical register tag for 64 physical registers
    typedef logic [PREG_W-1:0] preg_t;

    // Operation code passed through to the functional unit
    typedef logic [OPCODE_W-1:0] opcode_t;

    // Functional-unit class of an instruction
    typedef logic [FUNIT_W-1:0] funit_t;

    // Entry position inside one bank
    typedef logic [ENTRY_IDX_W-1:0] entry_idx_t;

    // Class codes accepted by the banks
    // Every other code finds no owning bank and is refused
    localparam funit_t FUNIT_ALU  = 2'd0;
    localparam funit_t FUNIT_MULT = 2'd1;

endpackage

`default_nettype wire

// File: src/rs_bank.sv
`timescale 1ns/1ps
`default_nettype none

module rs_bank import rs_pkg::*; #(
    parameter int     NUM_ENTRIES = 4,
    parameter funit_t BANK_UNIT   = FUNIT_ALU
) (
    input  logic                   clock,
    input  logic                   reset,

    // Allocation request, shared by all banks
    input  logic                   allocate,
    input  funit_t                 funit,
    input  opcode_t                opcode,
    input  preg_t                  dest_tag,
    input  preg_t                  src1_tag,
    input  logic                   src1_ready,
    input  preg_t                  src2_tag,
    input  logic                   src2_ready,
    output logic                   alloc_ok,

    // Result bus broadcast
    input  logic                   update,
    input  preg_t                  ready_tag,

    // Per-entry release from the functional units
    input  logic [NUM_ENTRIES-1:0] free,
    output logic                   full,

    // Issue candidate and grant from the selector
    input  logic                   grant,
    output logic                   issuable,
    output entry_idx_t             issue_entry,
    output preg_t                  issue_dest,
    output opcode_t                issue_opcode
);

    // Bank size has to fit the entry index
    if (NUM_ENTRIES < 1 || NUM_ENTRIES > MAX_RS_ENTRIES) begin : g_size_check
        $error("rs_bank NUM_ENTRIES out of range");
    end

    // Control state per entry
    logic [NUM_ENTRIES-1:0] busy;
    logic [NUM_ENTRIES-1:0] issued;

    // Operand readiness per entry
    logic [NUM_ENTRIES-1:0] src1_rdy;
    logic [NUM_ENTRIES-1:0] src2_rdy;

    // Stored instruction fields
    preg_t   dest_q    [NUM_ENTRIES];
    preg_t   src1_tag_q[NUM_ENTRIES];
    preg_t   src2_tag_q[NUM_ENTRIES];
    opcode_t opcode_q  [NUM_ENTRIES];

    logic       class_match;
    logic       free_found;
    entry_idx_t free_idx;
    logic       alloc_src1_rdy;
    logic       alloc_src2_rdy;

    // Only this bank's class is accepted here
    assign class_match = (funit == BANK_UNIT);
    assign alloc_ok    = allocate && class_match && free_found;

    // Full once every entry holds an instruction
    assign full = &busy;

    // Snoop the result bus on the allocation cycle so no wakeup slips by
    assign alloc_src1_rdy = src1_ready || (update && (src1_tag == ready_tag));
    assign alloc_src2_rdy = src2_ready || (update && (src2_tag == ready_tag));

    // Lowest free entry for allocation
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!busy[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = entry_idx_t'(i);
            end
        end
    end

    // Lowest entry that is busy, not yet issued and has both operands
    always_comb begin
        issuable     = 1'b0;
        issue_entry  = '0;
        issue_dest   = '0;
        issue_opcode = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (busy[i] && !issued[i] && src1_rdy[i] && src2_rdy[i] && !issuable) begin
                issuable     = 1'b1;
                issue_entry  = entry_idx_t'(i);
                issue_dest   = dest_q[i];
                issue_opcode = opcode_q[i];
            end
        end
    end

    // Busy and issued flags
    always_ff @(posedge clock) begin
        if (reset) begin
            busy   <= '0;
            issued <= '0;
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                // Selector granted this bank its current candidate
                if (grant && issuable && (issue_entry == entry_idx_t'(i))) begin
                    issued[i] <= 1'b1;
                end

                if (free[i]) begin
                    busy[i] <= 1'b0;
                end

                // Allocation only targets idle entries, so it wins over a stray free
                if (alloc_ok && (free_idx == entry_idx_t'(i))) begin
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                end
            end
        end
    end

    // Entry payload and operand readiness
    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // Wakeup from the result bus
            if (update && busy[i]) begin
                if (src1_tag_q[i] == ready_tag) begin
                    src1_rdy[i] <= 1'b1;
                end
                if (src2_tag_q[i] == ready_tag) begin
                    src2_rdy[i] <= 1'b1;
                end
            end

            if (alloc_ok && (free_idx == entry_idx_t'(i))) begin
                dest_q[i]     <= dest_tag;
                opcode_q[i]   <= opcode;
                src1_tag_q[i] <= src1_tag;
                src2_tag_q[i] <= src2_tag;
                src1_rdy[i]   <= alloc_src1_rdy;
                src2_rdy[i]   <= alloc_src2_rdy;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select import rs_pkg::*; (
    input  logic       clock,
    input  logic       reset,

    // Execute stage accepts an instruction this cycle
    input  logic       issue_enable,

    // Allocation results from the banks
    input  logic       alu_alloc_ok,
    input  logic       mult_alloc_ok,

    // ALU bank candidate
    input  logic       alu_issuable,
    input  entry_idx_t alu_entry,
    input  preg_t      alu_dest,
    input  opcode_t    alu_opcode,

    // Multiply bank candidate
    input  logic       mult_issuable,
    input  entry_idx_t mult_entry,
    input  preg_t      mult_dest,
    input  opcode_t    mult_opcode,

    // Grants back to the banks
    output logic       alu_grant,
    output logic       mult_grant,

    // Allocation response
    output logic       done,

    // Issued instruction
    output logic       issue_valid,
    output funit_t     issue_unit,
    output entry_idx_t issue_entry,
    output preg_t      issue_dest,
    output opcode_t    issue_opcode
);

    // Fixed priority with ALU ahead of multiply
    assign alu_grant  = issue_enable && alu_issuable;
    assign mult_grant = issue_enable && !alu_issuable && mult_issuable;

    // Done pulse and issue valid
    always_ff @(posedge clock) begin
        if (reset) begin
            done        <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            // At most one bank owns a class, so at most one can accept
            done        <= alu_alloc_ok || mult_alloc_ok;
            issue_valid <= alu_grant || mult_grant;
        end
    end

    // Fields of the granted candidate
    always_ff @(posedge clock) begin
        if (alu_grant) begin
            issue_unit   <= FUNIT_ALU;
            issue_entry  <= alu_entry;
            issue_dest   <= alu_dest;
            issue_opcode <= alu_opcode;
        end else if (mult_grant) begin
            issue_unit   <= FUNIT_MULT;
            issue_entry  <= mult_entry;
            issue_dest   <= mult_dest;
            issue_opcode <= mult_opcode;
        end
    end

endmodule

`default_nettype wire

// File: src/rs_top.sv
`timescale 1ns/1ps
`default_nettype none

module rs_top import rs_pkg::*; #(
    parameter int NUM_ALU_ENTRIES  = 4,
    parameter int NUM_MULT_ENTRIES = 2
) (
    input  logic                        clock,
    input  logic                        reset,

    // Allocation from dispatch
    input  logic                        allocate,
    input  funit_t                      funit,
    input  opcode_t                     opcode,
    input  preg_t                       dest_tag,
    input  preg_t                       src1_tag,
    input  logic                        src1_ready,
    input  preg_t                       src2_tag,
    input  logic                        src2_ready,
    output logic                        done,

    // Result bus
    input  logic                        update,
    input  preg_t                       ready_tag,

    // Issue
    input  logic                        issue_enable,
    output logic                        issue_valid,
    output funit_t                      issue_unit,
    output entry_idx_t                  issue_entry,
    output preg_t                       issue_dest,
    output opcode_t                     issue_opcode,

    // Occupancy and release
    output logic                        alu_full,
    output logic                        mult_full,
    input  logic [NUM_ALU_ENTRIES-1:0]  free_alu,
    input  logic [NUM_MULT_ENTRIES-1:0] free_mult
);

    logic       alu_alloc_ok;
    logic       alu_issuable;
    entry_idx_t alu_entry;
    preg_t      alu_dest;
    opcode_t    alu_opcode;
    logic       alu_grant;

    logic       mult_alloc_ok;
    logic       mult_issuable;
    entry_idx_t mult_entry;
    preg_t      mult_dest;
    opcode_t    mult_opcode;
    logic       mult_grant;

    rs_bank #(
        .NUM_ENTRIES (NUM_ALU_ENTRIES),
        .BANK_UNIT   (FUNIT_ALU)
    ) i_alu_bank (
        .clock        (clock),
        .reset        (reset),
        .allocate     (allocate),
        .funit        (funit),
        .opcode       (opcode),
        .dest_tag     (dest_tag),
        .src1_tag     (src1_tag),
        .src1_ready   (src1_ready),
        .src2_tag     (src2_tag),
        .src2_ready   (src2_ready),
        .alloc_ok     (alu_alloc_ok),
        .update       (update),
        .ready_tag    (ready_tag),
        .free         (free_alu),
        .full         (alu_full),
        .grant        (alu_grant),
        .issuable     (alu_issuable),
        .issue_entry  (alu_entry),
        .issue_dest   (alu_dest),
        .issue_opcode (alu_opcode)
    );

    rs_bank #(
        .NUM_ENTRIES (NUM_MULT_ENTRIES),
        .BANK_UNIT   (FUNIT_MULT)
    ) i_mult_bank (
        .clock        (clock),
        .reset        (reset),
        .allocate     (allocate),
        .funit        (funit),
        .opcode       (opcode),
        .dest_tag     (dest_tag),
        .src1_tag     (src1_tag),
        .src1_ready   (src1_ready),
        .src2_tag     (src2_tag),
        .src2_ready   (src2_ready),
        .alloc_ok     (mult_alloc_ok),
        .update       (update),
        .ready_tag    (ready_tag),
        .free         (free_mult),
        .full         (mult_full),
        .grant        (mult_grant),
        .issuable     (mult_issuable),
        .issue_entry  (mult_entry),
        .issue_dest   (mult_dest),
        .issue_opcode (mult_opcode)
    );

    issue_select i_issue_select (
        .clock         (clock),
        .reset         (reset),
        .issue_enable  (issue_enable),
        .alu_alloc_ok  (alu_alloc_ok),
        .mult_alloc_ok (mult_alloc_ok),
        .alu_issuable  (alu_issuable),
        .alu_entry     (alu_entry),
        .alu_dest      (alu_dest),
        .alu_opcode    (alu_opcode),
        .mult_issuable (mult_issuable),
        .mult_entry    (mult_entry),
        .mult_dest     (mult_dest),
        .mult_opcode   (mult_opcode),
        .alu_grant     (alu_grant),
        .mult_grant    (mult_grant),
        .done          (done),
        .issue_valid   (issue_valid),
        .issue_unit    (issue_unit),
        .issue_entry   (issue_entry),
        .issue_dest    (issue_dest),
        .issue_opcode  (issue_opcode)
    );

endmodule

`default_nettype wire

// File: verification/rs_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rs_asserts (
    input logic clock,
    input logic reset,
    input logic issue_enable,
    input logic alu_alloc_ok,
    input logic mult_alloc_ok,
    input logic alu_grant,
    input logic mult_grant,
    input logic done,
    input logic issue_valid
);

    // An issued instruction needs the execute stage to have accepted it
    a_issue_after_enable: assert property (
        @(posedge clock) disable iff (reset) issue_valid |-> $past(issue_enable)
    ) else $error("issue_valid without issue_enable on the previous edge");

    // Only one bank is granted per cycle
    a_single_grant: assert property (
        @(posedge clock) disable iff (reset) !(alu_grant && mult_grant)
    ) else $error("alu_grant and mult_grant high together");

    // Done follows an accepted allocation
    a_done_after_alloc: assert property (
        @(posedge clock) disable iff (reset) done |-> $past(alu_alloc_ok || mult_alloc_ok)
    ) else $error("done without alloc_ok on the previous edge");

    a_quiet_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> (!issue_valid && !done)
    ) else $error("issue_valid or done high in the cycle after reset");

endmodule

`default_nettype wire

// File: verification/rs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rs_tb import rs_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;
    localparam int NUM_ALU    = 4;
    localparam int NUM_MULT   = 2;

    logic                clock;
    logic                reset;
    logic                allocate;
    funit_t              funit;
    opcode_t             opcode;
    preg_t               dest_tag;
    preg_t               src1_tag;
    logic                src1_ready;
    preg_t               src2_tag;
    logic                src2_ready;
    logic                update;
    preg_t               ready_tag;
    logic                issue_enable;
    logic [NUM_ALU-1:0]  free_alu;
    logic [NUM_MULT-1:0] free_mult;
    logic                done;
    logic                alu_full;
    logic                mult_full;
    logic                issue_valid;
    funit_t              issue_unit;
    entry_idx_t          issue_entry;
    preg_t               issue_dest;
    opcode_t             issue_opcode;

    int seed;
    int errors;
    int errors_before;
    int tests;

    // Expected bank contents with bank 0 for ALU and bank 1 for multiply
    logic    m_busy  [2][4];
    logic    m_issued[2][4];
    logic    m_rdy1  [2][4];
    logic    m_rdy2  [2][4];
    preg_t   m_src1  [2][4];
    preg_t   m_src2  [2][4];
    preg_t   m_dest  [2][4];
    opcode_t m_op    [2][4];

    rs_top i_dut (
        .clock        (clock),
        .reset        (reset),
        .allocate     (allocate),
        .funit        (funit),
        .opcode       (opcode),
        .dest_tag     (dest_tag),
        .src1_tag     (src1_tag),
        .src1_ready   (src1_ready),
        .src2_tag     (src2_tag),
        .src2_ready   (src2_ready),
        .done         (done),
        .update       (update),
        .ready_tag    (ready_tag),
        .issue_enable (issue_enable),
        .issue_valid  (issue_valid),
        .issue_unit   (issue_unit),
        .issue_entry  (issue_entry),
        .issue_dest   (issue_dest),
        .issue_opcode (issue_opcode),
        .alu_full     (alu_full),
        .mult_full    (mult_full),
        .free_alu     (free_alu),
        .free_mult    (free_mult)
    );

    bind issue_select rs_asserts i_asserts (
        .clock         (clock),
        .reset         (reset),
        .issue_enable  (issue_enable),
        .alu_alloc_ok  (alu_alloc_ok),
        .mult_alloc_ok (mult_alloc_ok),
        .alu_grant     (alu_grant),
        .mult_grant    (mult_grant),
        .done          (done),
        .issue_valid   (issue_valid)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Watchdog sized at 200 cycles per test
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Run timed out before all tests completed");
        $display("Finished with errors");
        $finish;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            errors++;
        end
    endtask

    function automatic int bank_size(input int b);
        return (b == 0) ? NUM_ALU : NUM_MULT;
    endfunction

    // Result bus match on every busy entry
    task automatic model_wakeup(input preg_t tag);
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < bank_size(b); i++) begin
                if (m_busy[b][i] && m_src1[b][i] == tag) begin
                    m_rdy1[b][i] = 1'b1;
                end
                if (m_busy[b][i] && m_src2[b][i] == tag) begin
                    m_rdy2[b][i] = 1'b1;
                end
            end
        end
    endtask

    // One allocation with an optional result bus broadcast in the same cycle
    task automatic alloc_instr(input funit_t fu, input opcode_t op,
                               input preg_t s1, input logic r1,
                               input preg_t s2, input logic r2,
                               input logic snoop, input preg_t snoop_tag);
        int    b;
        int    slot;
        preg_t dest;
        b    = (fu == FUNIT_ALU) ? 0 : 1;
        slot = -1;
        dest = preg_t'($random(seed));
        if (fu == FUNIT_ALU || fu == FUNIT_MULT) begin
            for (int i = bank_size(b) - 1; i >= 0; i--) begin
                if (!m_busy[b][i]) begin
                    slot = i;
                end
            end
        end
        allocate   = 1'b1;
        funit      = fu;
        opcode     = op;
        dest_tag   = dest;
        src1_tag   = s1;
        src1_ready = r1;
        src2_tag   = s2;
        src2_ready = r2;
        update     = snoop;
        ready_tag  = snoop_tag;
        @(posedge clock);
        @(negedge clock);
        allocate = 1'b0;
        update   = 1'b0;
        check(32'(done), 32'(slot >= 0), "done after allocate");
        if (snoop) begin
            model_wakeup(snoop_tag);
        end
        if (slot >= 0) begin
            m_busy[b][slot]   = 1'b1;
            m_issued[b][slot] = 1'b0;
            m_src1[b][slot]   = s1;
            m_src2[b][slot]   = s2;
            m_rdy1[b][slot]   = r1 || (snoop && s1 == snoop_tag);
            m_rdy2[b][slot]   = r2 || (snoop && s2 == snoop_tag);
            m_dest[b][slot]   = dest;
            m_op[b][slot]     = op;
        end
        @(negedge clock);
        check(32'(done), 32'd0, "done one cycle later");
    endtask

    task automatic broadcast(input preg_t tag);
        update    = 1'b1;
        ready_tag = tag;
        @(posedge clock);
        @(negedge clock);
        update = 1'b0;
        model_wakeup(tag);
    endtask

    task automatic release_entries(input int b, input logic [3:0] mask);
        if (b == 0) begin
            free_alu = mask[NUM_ALU-1:0];
        end else begin
            free_mult = mask[NUM_MULT-1:0];
        end
        @(posedge clock);
        @(negedge clock);
        free_alu  = '0;
        free_mult = '0;
        for (int i = 0; i < bank_size(b); i++) begin
            if (mask[i]) begin
                m_busy[b][i] = 1'b0;
            end
        end
    endtask

    // Lowest ready ALU entry first, then lowest ready multiply entry
    task automatic issue_step(input logic en);
        logic found;
        int   eb;
        int   ei;
        found = 1'b0;
        eb    = 0;
        ei    = 0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < bank_size(b); i++) begin
                if (en && !found && m_busy[b][i] && !m_issued[b][i]
                        && m_rdy1[b][i] && m_rdy2[b][i]) begin
                    found = 1'b1;
                    eb    = b;
                    ei    = i;
                end
            end
        end
        issue_enable = en;
        @(posedge clock);
        @(negedge clock);
        issue_enable = 1'b0;
        check(32'(issue_valid), 32'(found), "issue_valid");
        if (found) begin
            check(32'(issue_unit), 32'((eb == 0) ? FUNIT_ALU : FUNIT_MULT), "issue_unit");
            check(32'(issue_entry), 32'(ei), "issue_entry");
            check(32'(issue_dest), 32'(m_dest[eb][ei]), "issue_dest");
            check(32'(issue_opcode), 32'(m_op[eb][ei]), "issue_opcode");
            m_issued[eb][ei] = 1'b1;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s done, %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic test_reset_state();
        check(32'(done), 32'd0, "done after reset");
        check(32'(issue_valid), 32'd0, "issue_valid after reset");
        check(32'(alu_full), 32'd0, "alu_full after reset");
        check(32'(mult_full), 32'd0, "mult_full after reset");
        issue_step(1'b1);
        finish_test("reset_state");
    endtask

    task automatic test_basic_issue();
        alloc_instr(FUNIT_ALU, 4'h3, 6'd1, 1'b1, 6'd2, 1'b1, 1'b0, '0);
        issue_step(1'b1);
        release_entries(0, 4'b0001);
        alloc_instr(FUNIT_MULT, 4'h9, 6'd3, 1'b1, 6'd4, 1'b1, 1'b0, '0);
        issue_step(1'b1);
        release_entries(1, 4'b0001);
        // Class codes without an owning bank
        alloc_instr(2'd2, 4'h1, 6'd5, 1'b1, 6'd6, 1'b1, 1'b0, '0);
        alloc_instr(2'd3, 4'h2, 6'd5, 1'b1, 6'd6, 1'b1, 1'b0, '0);
        finish_test("basic_issue");
    endtask

    task automatic test_wakeup();
        alloc_instr(FUNIT_ALU, 4'h5, 6'd10, 1'b0, 6'd11, 1'b1, 1'b0, '0);
        issue_step(1'b1);
        broadcast(6'd10);
        issue_step(1'b1);
        release_entries(0, 4'b0001);
        // Tag broadcast in the allocation cycle itself
        alloc_instr(FUNIT_ALU, 4'h6, 6'd20, 1'b0, 6'd21, 1'b1, 1'b1, 6'd20);
        issue_step(1'b1);
        release_entries(0, 4'b0001);
        finish_test("wakeup");
    endtask

    task automatic test_full_free();
        for (int k = 0; k < NUM_ALU; k++) begin
            alloc_instr(FUNIT_ALU, opcode_t'(k), 6'd30, 1'b1, 6'd31, 1'b1, 1'b0, '0);
        end
        check(32'(alu_full), 32'd1, "alu_full with all entries busy");
        alloc_instr(FUNIT_ALU, 4'hf, 6'd30, 1'b1, 6'd31, 1'b1, 1'b0, '0);
        for (int k = 0; k < NUM_ALU; k++) begin
            issue_step(1'b1);
        end
        release_entries(0, 4'b0100);
        check(32'(alu_full), 32'd0, "alu_full after free");
        alloc_instr(FUNIT_ALU, 4'ha, 6'd32, 1'b1, 6'd33, 1'b1, 1'b0, '0);
        issue_step(1'b1);
        release_entries(0, 4'b1111);
        finish_test("full_free");
    endtask

    task automatic test_priority();
        alloc_instr(FUNIT_MULT, 4'h7, 6'd40, 1'b1, 6'd41, 1'b1, 1'b0, '0);
        alloc_instr(FUNIT_MULT, 4'h8, 6'd42, 1'b1, 6'd43, 1'b1, 1'b0, '0);
        check(32'(mult_full), 32'd1, "mult_full with both entries busy");
        for (int k = 0; k < NUM_ALU; k++) begin
            alloc_instr(FUNIT_ALU, opcode_t'(k + 1), 6'd44, 1'b1, 6'd45, 1'b1, 1'b0, '0);
        end
        // Execute stage stalled
        repeat (3) issue_step(1'b0);
        repeat (NUM_ALU + NUM_MULT + 1) issue_step(1'b1);
        release_entries(0, 4'b1111);
        release_entries(1, 4'b0011);
        finish_test("priority");
    endtask

    initial begin
        seed          = 22633;
        errors        = 0;
        errors_before = 0;
        tests         = 0;
        clock         = 1'b0;
        reset         = 1'b1;
        allocate      = 1'b0;
        funit         = '0;
        opcode        = '0;
        dest_tag      = '0;
        src1_tag      = '0;
        src1_ready    = 1'b0;
        src2_tag      = '0;
        src2_ready    = 1'b0;
        update        = 1'b0;
        ready_tag     = '0;
        issue_enable  = 1'b0;
        free_alu      = '0;
        free_mult     = '0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 4; i++) begin
                m_busy[b][i]   = 1'b0;
                m_issued[b][i] = 1'b0;
            end
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_reset_state();
        test_basic_issue();
        test_wakeup();
        test_full_free();
        test_priority();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/rs_pkg.sv
src/rs_bank.sv
src/issue_select.sv
src/rs_top.sv
verification/rs_asserts.sv
verification/rs_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the scheduler testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module rs_tb -o rs_sim &&
./obj_dir/rs_sim | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
